// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= btac_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = TESTS PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list.
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Run from the project root so the data file path resolves.
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/btac_tb.sv ====
`timescale 1ns/1ps

module btac_tb
  import btac_config_pkg::*, btac_types_pkg::*;
();

  localparam int record_words = 15; // Control word, two fetch PCs, six words per slot.
  localparam int max_records = 64;
  localparam logic [31:0] end_marker = 32'hffff_ffff;

  logic clock;
  logic reset;
  logic stall;
  logic clear;
  logic [addr_width-1:0] fetch_pc0;
  logic [addr_width-1:0] fetch_pc1;
  logic pred_taken0;
  logic pred_taken1;
  logic [addr_width-1:0] pred_target;
  logic [addr_width-1:0] pred_pc;
  logic [addr_width-1:0] pred_npc;
  resolve_kind_t resolve_kind0;
  logic [addr_width-1:0] resolve_pc0;
  logic [addr_width-1:0] resolve_target0;
  logic [addr_width-1:0] resolve_npc0;
  logic carried_taken0;
  logic [addr_width-1:0] carried_pc0;
  logic [addr_width-1:0] carried_target0;
  logic [addr_width-1:0] carried_npc0;
  resolve_kind_t resolve_kind1;
  logic [addr_width-1:0] resolve_pc1;
  logic [addr_width-1:0] resolve_target1;
  logic [addr_width-1:0] resolve_npc1;
  logic carried_taken1;
  logic [addr_width-1:0] carried_pc1;
  logic [addr_width-1:0] carried_target1;
  logic [addr_width-1:0] carried_npc1;
  logic miss;
  logic [addr_width-1:0] miss_target;
  logic hazard;

  logic [31:0] testdata [max_records*record_words];
  int record_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int check_count = 0;
  int error_count = 0;
  int unsigned seed_discard;
  logic checking = 1'b0;

  // Reference model of the buffer and the registered state around it.
  logic [btb_entries-1:0] model_valid;
  logic [addr_width-1:0] model_target [btb_entries];
  logic [addr_width-1:0] model_pc [btb_entries];
  logic [addr_width-1:0] model_npc [btb_entries];
  logic [addr_width-1:0] model_pc0_q;
  logic [addr_width-1:0] model_pc1_q;
  logic model_miss;
  logic [addr_width-1:0] model_miss_target;

  btac btac_i (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  function automatic logic is_taken(resolve_kind_t kind);
    return (kind == resolve_jump) || (kind == resolve_branch_taken);
  endfunction

  function automatic logic [btb_index_width-1:0] entry_index(logic [addr_width-1:0] pc);
    return pc[btb_index_lsb +: btb_index_width];
  endfunction

  // Redirect decision for the resolve inputs currently applied.
  task automatic resolve_outcome(output logic any_miss, output logic slot0_miss,
                                 output logic [addr_width-1:0] redirect);
    logic pred0;
    logic pred1;
    pred0 = carried_taken0 && (carried_pc0 == resolve_pc0);
    pred1 = carried_taken1 && (carried_pc1 == resolve_pc1);
    any_miss = 1'b0;
    slot0_miss = 1'b0;
    redirect = '0;
    if (clear) begin
      any_miss = 1'b0;
    end else if (pred0) begin
      if (is_taken(resolve_kind0)) begin
        redirect = resolve_target0;
        any_miss = resolve_target0 != carried_target0;
        slot0_miss = any_miss;
      end else if (resolve_kind0 == resolve_branch_not_taken) begin
        redirect = carried_npc0;
        any_miss = 1'b1;
        slot0_miss = 1'b1;
      end
    end else if (pred1) begin
      if (is_taken(resolve_kind1)) begin
        redirect = resolve_target1;
        any_miss = resolve_target1 != carried_target1;
      end else if (resolve_kind1 == resolve_branch_not_taken) begin
        redirect = carried_npc1;
        any_miss = 1'b1;
      end
    end else if (is_taken(resolve_kind0)) begin
      redirect = resolve_target0;
      any_miss = 1'b1;
      slot0_miss = 1'b1;
    end else if (is_taken(resolve_kind1)) begin
      redirect = resolve_target1;
      any_miss = 1'b1;
    end
  endtask

  task automatic check_value(input string name, input logic [addr_width-1:0] actual,
                             input logic [addr_width-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: got %h, expected %h (cycle %0d)", name, actual, expected,
               cycle_count);
    end
  endtask

  task automatic drive_quiet();
    stall <= 1'b0;
    clear <= 1'b0;
    fetch_pc0 <= '0;
    fetch_pc1 <= '0;
    resolve_kind0 <= resolve_none;
    resolve_pc0 <= '0;
    resolve_target0 <= '0;
    resolve_npc0 <= '0;
    carried_taken0 <= 1'b0;
    carried_pc0 <= '0;
    carried_target0 <= '0;
    carried_npc0 <= '0;
    resolve_kind1 <= resolve_none;
    resolve_pc1 <= '0;
    resolve_target1 <= '0;
    resolve_npc1 <= '0;
    carried_taken1 <= 1'b0;
    carried_pc1 <= '0;
    carried_target1 <= '0;
    carried_npc1 <= '0;
  endtask

  // Fetch PCs and clear stay as they were.
  task automatic drive_idle();
    stall <= 1'b1;
    resolve_kind0 <= resolve_none;
    resolve_kind1 <= resolve_none;
    carried_taken0 <= 1'b0;
    carried_taken1 <= 1'b0;
  endtask

  task automatic apply_record(input int r);
    int base;
    logic [31:0] ctrl;
    base = r * record_words;
    ctrl = testdata[base];
    stall <= ctrl[0];
    clear <= ctrl[4];
    resolve_kind0 <= resolve_kind_t'(ctrl[9:8]);
    carried_taken0 <= ctrl[12];
    resolve_kind1 <= resolve_kind_t'(ctrl[17:16]);
    carried_taken1 <= ctrl[20];
    fetch_pc0 <= testdata[base+1];
    fetch_pc1 <= testdata[base+2];
    resolve_pc0 <= testdata[base+3];
    resolve_target0 <= testdata[base+4];
    resolve_npc0 <= testdata[base+5];
    carried_pc0 <= testdata[base+6];
    carried_target0 <= testdata[base+7];
    carried_npc0 <= testdata[base+8];
    resolve_pc1 <= testdata[base+9];
    resolve_target1 <= testdata[base+10];
    resolve_npc1 <= testdata[base+11];
    carried_pc1 <= testdata[base+12];
    carried_target1 <= testdata[base+13];
    carried_npc1 <= testdata[base+14];
  endtask

  always @(posedge clock) begin : model_update
    logic any_miss;
    logic slot0_miss;
    logic [addr_width-1:0] redirect;
    logic [btb_index_width-1:0] idx;
    if (!reset) begin
      model_valid <= '0;
      model_pc0_q <= '0;
      model_pc1_q <= '0;
      model_miss <= 1'b0;
      model_miss_target <= '0;
    end else begin
      resolve_outcome(any_miss, slot0_miss, redirect);
      if (!clear && (is_taken(resolve_kind0) || is_taken(resolve_kind1))) begin
        idx = is_taken(resolve_kind0) ? entry_index(resolve_pc0) : entry_index(resolve_pc1);
        model_valid[idx] <= 1'b1;
        model_target[idx] <= is_taken(resolve_kind0) ? resolve_target0 : resolve_target1;
        model_pc[idx] <= is_taken(resolve_kind0) ? resolve_pc0 : resolve_pc1;
        model_npc[idx] <= is_taken(resolve_kind0) ? resolve_npc0 : resolve_npc1;
      end
      if (!clear) begin
        model_pc0_q <= fetch_pc0;
        model_pc1_q <= fetch_pc1;
      end
      model_miss <= any_miss;
      model_miss_target <= redirect;
    end
  end

  // Outputs settle well before the falling edge.
  always @(negedge clock) begin : check_outputs
    logic exp_taken0;
    logic exp_taken1;
    logic [addr_width-1:0] exp_target;
    logic [addr_width-1:0] exp_pc;
    logic [addr_width-1:0] exp_npc;
    logic any_miss;
    logic slot0_miss;
    logic [addr_width-1:0] redirect;
    logic [btb_index_width-1:0] idx0;
    logic [btb_index_width-1:0] idx1;
    if (checking) begin
      idx0 = entry_index(model_pc0_q);
      idx1 = entry_index(model_pc1_q);
      exp_taken0 = !stall && !clear && model_valid[idx0] && (model_pc[idx0] == model_pc0_q);
      exp_taken1 = !stall && !clear && model_valid[idx1] && (model_pc[idx1] == model_pc1_q);
      exp_target = exp_taken0 ? model_target[idx0] : exp_taken1 ? model_target[idx1] : '0;
      exp_pc = exp_taken0 ? model_pc[idx0] : exp_taken1 ? model_pc[idx1] : '0;
      exp_npc = exp_taken0 ? model_npc[idx0] : exp_taken1 ? model_npc[idx1] : '0;
      resolve_outcome(any_miss, slot0_miss, redirect);
      check_value("pred_taken0", addr_width'(pred_taken0), addr_width'(exp_taken0));
      check_value("pred_taken1", addr_width'(pred_taken1), addr_width'(exp_taken1));
      check_value("pred_target", pred_target, exp_target);
      check_value("pred_pc", pred_pc, exp_pc);
      check_value("pred_npc", pred_npc, exp_npc);
      check_value("hazard", addr_width'(hazard), addr_width'(slot0_miss));
      check_value("miss", addr_width'(miss), addr_width'(model_miss));
      if (model_miss) begin
        check_value("miss_target", miss_target, model_miss_target);
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    seed_discard = $urandom(32'h1674_9687);
    reset <= 1'b0;
    drive_quiet();
    $readmemh("sim/btac_testdata.hex", testdata);
    while (record_count < max_records &&
           testdata[record_count*record_words] != end_marker) begin
      record_count++;
    end
    cycle_limit = 2 * record_count + 50;
    if (record_count == 0) begin
      $display("No stimulus records were read from sim/btac_testdata.hex");
      error_count++;
    end
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    checking <= 1'b1;
    for (int r = 0; r < record_count; r++) begin
      @(posedge clock);
      apply_record(r);
      if ($urandom_range(3) == 0) begin
        @(posedge clock);
        drive_idle();
      end
    end
    @(posedge clock);
    drive_quiet();
    repeat (2) @(posedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/btac_testdata.hex ====
// ctrl digits high to low: carried_taken1 kind1 carried_taken0 kind0 clear stall
// then fetch_pc0 fetch_pc1, slot 0 resolve pc/target/npc and carried pc/target/npc, slot 1 alike
000000 100 104 0 0 0 0 0 0 0 0 0 0 0 0
000000 200 204 0 0 0 0 0 0 0 0 0 0 0 0
010000 300 304 0 0 0 0 0 0 1040 3000 1044 0 0 0
000000 1040 2040 0 0 0 0 0 0 0 0 0 0 0 0
000000 400 404 0 0 0 0 0 0 0 0 0 0 0 0
000100 500 504 1080 5000 1084 0 0 0 0 0 0 0 0 0
000000 1080 1040 0 0 0 0 0 0 0 0 0 0 0 0
000000 1080 1040 0 0 0 0 0 0 0 0 0 0 0 0
000001 1080 1040 0 0 0 0 0 0 0 0 0 0 0 0
000000 1040 1080 0 0 0 0 0 0 0 0 0 0 0 0
000000 600 604 0 0 0 0 0 0 0 0 0 0 0 0
001100 600 604 1080 5000 1084 1080 5000 1084 0 0 0 0 0 0
001200 600 604 1040 3400 1044 1040 3000 1044 0 0 0 0 0 0
001300 1040 10c0 10c0 0 10c4 10c0 7000 10c4 0 0 0 0 0 0
110000 700 704 0 0 0 0 0 0 1080 5000 1084 1080 5000 1084
120000 700 704 0 0 0 0 0 0 1100 7700 1104 1100 7600 1104
130000 700 704 0 0 0 0 0 0 1140 0 1144 1140 8000 1144
001100 700 704 1180 9000 1184 1184 9000 1188 0 0 0 0 0 0
020100 700 704 11c0 a000 11c4 0 0 0 1200 b000 1204 0 0 0
000000 11c0 1200 0 0 0 0 0 0 0 0 0 0 0 0
000000 800 804 0 0 0 0 0 0 0 0 0 0 0 0
011000 900 904 1300 0 1304 1300 4000 1304 1340 c000 1344 0 0 0
000110 1340 1380 1380 d000 1384 0 0 0 0 0 0 0 0 0
000000 1380 1340 0 0 0 0 0 0 0 0 0 0 0 0
000000 a00 a04 0 0 0 0 0 0 0 0 0 0 0 0
000000 1340 1340 0 0 0 0 0 0 0 0 0 0 0 0
000010 100 104 0 0 0 0 0 0 0 0 0 0 0 0
000000 100 104 0 0 0 0 0 0 0 0 0 0 0 0
000000 100 104 0 0 0 0 0 0 0 0 0 0 0 0
000101 1400 104 1400 e000 1404 0 0 0 0 0 0 0 0 0
000000 1400 100 0 0 0 0 0 0 0 0 0 0 0 0
000000 100 104 0 0 0 0 0 0 0 0 0 0 0 0
// End of records.
ffffffff

// ==== src.f ====
verilog/btac_config_pkg.sv
verilog/btac_types_pkg.sv
verilog/btb_ram.sv
verilog/btac_lookup.sv
verilog/btac_update.sv
verilog/btac.sv
sim/btac_tb.sv

// ==== verilog/btac.sv ====
`timescale 1ns/1ps

module btac
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic [addr_width-1:0] fetch_pc0,
  input logic [addr_width-1:0] fetch_pc1,
  output logic pred_taken0,
  output logic pred_taken1,
  output logic [addr_width-1:0] pred_target,
  output logic [addr_width-1:0] pred_pc,
  output logic [addr_width-1:0] pred_npc,
  input resolve_kind_t resolve_kind0,
  input logic [addr_width-1:0] resolve_pc0,
  input logic [addr_width-1:0] resolve_target0,
  input logic [addr_width-1:0] resolve_npc0,
  input logic carried_taken0,
  input logic [addr_width-1:0] carried_pc0,
  input logic [addr_width-1:0] carried_target0,
  input logic [addr_width-1:0] carried_npc0,
  input resolve_kind_t resolve_kind1,
  input logic [addr_width-1:0] resolve_pc1,
  input logic [addr_width-1:0] resolve_target1,
  input logic [addr_width-1:0] resolve_npc1,
  input logic carried_taken1,
  input logic [addr_width-1:0] carried_pc1,
  input logic [addr_width-1:0] carried_target1,
  input logic [addr_width-1:0] carried_npc1,
  output logic miss,
  output logic [addr_width-1:0] miss_target,
  output logic hazard
);

  logic write_enable;
  logic [btb_index_width-1:0] write_index;
  logic [entry_width-1:0] write_data;
  logic [btb_index_width-1:0] read_index0;
  logic [btb_index_width-1:0] read_index1;
  logic [entry_width-1:0] read_data0;
  logic [entry_width-1:0] read_data1;

  btb_ram btb_ram_i (
    .clock (clock),
    .reset (reset),
    .write_enable (write_enable),
    .write_index (write_index),
    .write_data (write_data),
    .read_index0 (read_index0),
    .read_index1 (read_index1),
    .read_data0 (read_data0),
    .read_data1 (read_data1)
  );

  btac_lookup btac_lookup_i (
    .clock (clock),
    .reset (reset),
    .stall (stall),
    .clear (clear),
    .fetch_pc0 (fetch_pc0),
    .fetch_pc1 (fetch_pc1),
    .read_index0 (read_index0),
    .read_index1 (read_index1),
    .read_data0 (read_data0),
    .read_data1 (read_data1),
    .pred_taken0 (pred_taken0),
    .pred_taken1 (pred_taken1),
    .pred_target (pred_target),
    .pred_pc (pred_pc),
    .pred_npc (pred_npc)
  );

  btac_update btac_update_i (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .resolve_kind0 (resolve_kind0),
    .resolve_pc0 (resolve_pc0),
    .resolve_target0 (resolve_target0),
    .resolve_npc0 (resolve_npc0),
    .carried_taken0 (carried_taken0),
    .carried_pc0 (carried_pc0),
    .carried_target0 (carried_target0),
    .carried_npc0 (carried_npc0),
    .resolve_kind1 (resolve_kind1),
    .resolve_pc1 (resolve_pc1),
    .resolve_target1 (resolve_target1),
    .resolve_npc1 (resolve_npc1),
    .carried_taken1 (carried_taken1),
    .carried_pc1 (carried_pc1),
    .carried_target1 (carried_target1),
    .carried_npc1 (carried_npc1),
    .write_enable (write_enable),
    .write_index (write_index),
    .write_data (write_data),
    .miss (miss),
    .hazard (hazard),
    .miss_target (miss_target)
  );

endmodule

// ==== verilog/btac_config_pkg.sv ====
package btac_config_pkg;

  // Width of fetch program counters and branch targets.
  localparam int addr_width = 32;

  // Number of buffer entries, kept at a power of two.
  localparam int btb_entries = 64;

  // Index bits taken from the PC.
  localparam int btb_index_width = $clog2(btb_entries);

  // Instructions are word aligned, so the index starts above the byte offset.
  localparam int btb_index_lsb = 2;

endpackage

// ==== verilog/btac_lookup.sv ====
`timescale 1ns/1ps

module btac_lookup
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic [addr_width-1:0] fetch_pc0,
  input logic [addr_width-1:0] fetch_pc1,
  output logic [btb_index_width-1:0] read_index0,
  output logic [btb_index_width-1:0] read_index1,
  input logic [entry_width-1:0] read_data0,
  input logic [entry_width-1:0] read_data1,
  output logic pred_taken0,
  output logic pred_taken1,
  output logic [addr_width-1:0] pred_target,
  output logic [addr_width-1:0] pred_pc,
  output logic [addr_width-1:0] pred_npc
);

  logic [addr_width-1:0] pc0_q;
  logic [addr_width-1:0] pc1_q;
  logic hit0;
  logic hit1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= fetch_pc0;
      pc1_q <= fetch_pc1;
    end
  end

  // On clear the RAM keeps reading the index of the held PC.
  always_comb begin
    if (clear) begin
      read_index0 = pc0_q[btb_index_lsb +: btb_index_width];
      read_index1 = pc1_q[btb_index_lsb +: btb_index_width];
    end else begin
      read_index0 = fetch_pc0[btb_index_lsb +: btb_index_width];
      read_index1 = fetch_pc1[btb_index_lsb +: btb_index_width];
    end
  end

  // Full pc compare stands in for a tag.
  assign hit0 = read_data0[entry_valid_bit] &&
                (read_data0[entry_pc_lsb +: addr_width] == pc0_q);
  assign hit1 = read_data1[entry_valid_bit] &&
                (read_data1[entry_pc_lsb +: addr_width] == pc1_q);

  assign pred_taken0 = !stall && !clear && hit0;
  assign pred_taken1 = !stall && !clear && hit1;

  always_comb begin
    if (pred_taken0) begin // Slot 0 wins.
      pred_target = read_data0[entry_target_lsb +: addr_width];
      pred_pc = read_data0[entry_pc_lsb +: addr_width];
      pred_npc = read_data0[entry_npc_lsb +: addr_width];
    end else if (pred_taken1) begin
      pred_target = read_data1[entry_target_lsb +: addr_width];
      pred_pc = read_data1[entry_pc_lsb +: addr_width];
      pred_npc = read_data1[entry_npc_lsb +: addr_width];
    end else begin
      pred_target = '0;
      pred_pc = '0;
      pred_npc = '0;
    end
  end

  // A prediction under stall would redirect a frozen fetch stage.
  no_pred_in_stall: assert property (@(posedge clock) disable iff (!reset)
    stall |-> !(pred_taken0 || pred_taken1));

endmodule

// ==== verilog/btac_types_pkg.sv ====
package btac_types_pkg;

  import btac_config_pkg::*;

  // Stored word holds valid, target, branch pc and next pc.
  localparam int entry_width = 3 * addr_width + 1;

  localparam int entry_valid_bit = 3 * addr_width; // Top bit.
  localparam int entry_target_lsb = 2 * addr_width;
  localparam int entry_pc_lsb = addr_width;
  localparam int entry_npc_lsb = 0;

  // Kind of each resolved instruction slot.
  typedef enum logic [1:0] {
    resolve_none,
    resolve_jump,
    resolve_branch_taken,
    resolve_branch_not_taken
  } resolve_kind_t;

endpackage

// ==== verilog/btac_update.sv ====
`timescale 1ns/1ps

module btac_update
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input resolve_kind_t resolve_kind0,
  input logic [addr_width-1:0] resolve_pc0,
  input logic [addr_width-1:0] resolve_target0,
  input logic [addr_width-1:0] resolve_npc0,
  input logic carried_taken0,
  input logic [addr_width-1:0] carried_pc0,
  input logic [addr_width-1:0] carried_target0,
  input logic [addr_width-1:0] carried_npc0,
  input resolve_kind_t resolve_kind1,
  input logic [addr_width-1:0] resolve_pc1,
  input logic [addr_width-1:0] resolve_target1,
  input logic [addr_width-1:0] resolve_npc1,
  input logic carried_taken1,
  input logic [addr_width-1:0] carried_pc1,
  input logic [addr_width-1:0] carried_target1,
  input logic [addr_width-1:0] carried_npc1,
  output logic write_enable,
  output logic [btb_index_width-1:0] write_index,
  output logic [entry_width-1:0] write_data,
  output logic miss,
  output logic hazard,
  output logic [addr_width-1:0] miss_target
);

  logic taken0;
  logic taken1;
  logic predicted0;
  logic predicted1;
  logic miss0;
  logic miss1;
  logic [addr_width-1:0] redirect;

  assign taken0 = (resolve_kind0 == resolve_jump) || (resolve_kind0 == resolve_branch_taken);
  assign taken1 = (resolve_kind1 == resolve_jump) || (resolve_kind1 == resolve_branch_taken);

  assign predicted0 = carried_taken0 && (carried_pc0 == resolve_pc0);
  assign predicted1 = carried_taken1 && (carried_pc1 == resolve_pc1);

  // Only one taken slot is written per cycle.
  assign write_enable = !clear && (taken0 || taken1);
  assign write_index = taken0 ? resolve_pc0[btb_index_lsb +: btb_index_width]
                              : resolve_pc1[btb_index_lsb +: btb_index_width];
  assign write_data = taken0 ? {1'b1, resolve_target0, resolve_pc0, resolve_npc0}
                             : {1'b1, resolve_target1, resolve_pc1, resolve_npc1};

  always_comb begin
    miss0 = 1'b0;
    miss1 = 1'b0;
    redirect = '0;
    if (!clear) begin
      if (predicted0) begin
        if (taken0) begin
          redirect = resolve_target0;
          miss0 = resolve_target0 != carried_target0; // Wrong target.
        end else if (resolve_kind0 == resolve_branch_not_taken) begin
          redirect = carried_npc0; // Fall through.
          miss0 = 1'b1;
        end
      end else if (predicted1) begin
        if (taken1) begin
          redirect = resolve_target1;
          miss1 = resolve_target1 != carried_target1;
        end else if (resolve_kind1 == resolve_branch_not_taken) begin
          redirect = carried_npc1;
          miss1 = 1'b1;
        end
      end else if (taken0) begin // Taken but never predicted.
        redirect = resolve_target0;
        miss0 = 1'b1;
      end else if (taken1) begin
        redirect = resolve_target1;
        miss1 = 1'b1;
      end
    end
  end

  assign hazard = miss0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss <= 1'b0;
      miss_target <= '0;
    end else begin
      miss <= miss0 || miss1;
      miss_target <= redirect;
    end
  end

  one_miss_slot: assert property (@(posedge clock) disable iff (!reset)
    !(miss0 && miss1));

endmodule

// ==== verilog/btb_ram.sv ====
`timescale 1ns/1ps

module btb_ram
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic write_enable,
  input logic [btb_index_width-1:0] write_index,
  input logic [entry_width-1:0] write_data,
  input logic [btb_index_width-1:0] read_index0,
  input logic [btb_index_width-1:0] read_index1,
  output logic [entry_width-1:0] read_data0,
  output logic [entry_width-1:0] read_data1
);

  logic [entry_valid_bit-1:0] payload [btb_entries];
  logic [btb_entries-1:0] valid;
  logic [btb_index_width-1:0] read_index0_q;
  logic [btb_index_width-1:0] read_index1_q;

  always_ff @(posedge clock) begin
    if (write_enable) begin
      payload[write_index] <= write_data[entry_valid_bit-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
      read_index0_q <= '0;
      read_index1_q <= '0;
    end else begin
      if (write_enable) begin
        valid[write_index] <= write_data[entry_valid_bit];
      end
      read_index0_q <= read_index0;
      read_index1_q <= read_index1;
    end
  end

  assign read_data0 = {valid[read_index0_q], payload[read_index0_q]}; // Async from registered address.
  assign read_data1 = {valid[read_index1_q], payload[read_index1_q]};

  write_index_known: assert property (@(posedge clock) disable iff (!reset)
    write_enable |-> !$isunknown(write_index));

endmodule
